//--- rtl/spritePkg.sv
package spritePkg;

    // one entity register, packed as the host writes it
    localparam int ENTITY_W = 20;

    // field positions inside an entity word
    localparam int ID_LSB     = 16;
    localparam int ORIENT_LSB = 14;
    localparam int COL_LSB    = 10;
    localparam int ROW_LSB    = 6;
    localparam int MODE_LSB   = 4;
    localparam int LEN_LSB    = 0;

    // sprite id for an unused slot
    localparam logic [3:0] ID_NONE = 4'd15;

    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_ARRAY  = 2'd1,
        MODE_FLIP   = 2'd2,
        MODE_OFF    = 2'd3
    } drawMode;

    // id 15, mode off, everything else zero
    localparam logic [ENTITY_W-1:0] ENTITY_RESET = {
        ID_NONE, 2'b00, 4'd0, 4'd0, MODE_OFF, 4'd0
    };

    // screen geometry
    localparam int TILE_SIZE = 8;
    localparam int COORD_W   = 10;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- rtl/entityRegs.sv
`timescale 1ns/1ps

module entityRegs #(
    parameter int unsigned numSlots = 9
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  awAddr,
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] wData,
    input  logic [3:0]  wStrb,
    input  logic        wValid,
    output logic        wReady,
    output logic [1:0]  bResp,
    output logic        bValid,
    input  logic        bReady,
    input  logic [5:0]  arAddr,
    input  logic        arValid,
    output logic        arReady,
    output logic [31:0] rData,
    output logic [1:0]  rResp,
    output logic        rValid,
    input  logic        rReady,
    output logic [numSlots*spritePkg::ENTITY_W-1:0] entityTable
);
    localparam int EW = spritePkg::ENTITY_W;
    localparam logic [4:0] SLOT_LIMIT = 5'(numSlots);

    logic [EW-1:0] slots [numSlots];
    logic          writeFire;
    logic          readFire;
    logic          writeOk;
    logic          readOk;
    logic [EW-1:0] readWord;

    // word aligned and inside the slot table
    function automatic logic addrOk(input logic [5:0] addr);
        return (addr[1:0] == 2'b00) && ({1'b0, addr[5:2]} < SLOT_LIMIT);
    endfunction

    // byte lanes above the entity width fall away on truncation
    function automatic logic [EW-1:0] mergeBytes(
        input logic [EW-1:0] old,
        input logic [31:0]   data,
        input logic [3:0]    strb
    );
        logic [31:0] merged;
        merged = {{(32-EW){1'b0}}, old};
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged[EW-1:0];
    endfunction

    assign writeFire = awValid && awReady && wValid && wReady;
    assign readFire  = arValid && arReady;
    assign writeOk   = addrOk(awAddr);
    assign readOk    = addrOk(arAddr);

    // read port is free whenever no read data waits
    assign arReady = !rValid;

    always_comb begin
        readWord = '0;
        for (int i = 0; i < numSlots; i++) begin
            if (arAddr[5:2] == 4'(i)) begin
                readWord = slots[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b0;
            rValid  <= 1'b0;
        end else begin
            // single-cycle ready pulse, only with no write response pending
            awReady <= awValid && wValid && !bValid && !awReady;
            wReady  <= awValid && wValid && !bValid && !awReady;
            if (writeFire) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (readFire) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeFire) begin
            bResp <= writeOk ? spritePkg::RESP_OKAY : spritePkg::RESP_SLVERR;
        end
        if (readFire) begin
            rData <= readOk ? {{(32-EW){1'b0}}, readWord} : 32'd0;
            rResp <= readOk ? spritePkg::RESP_OKAY : spritePkg::RESP_SLVERR;
        end
    end

    // slot table, all slots disabled out of reset
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < numSlots; i++) begin
                slots[i] <= spritePkg::ENTITY_RESET;
            end
        end else if (writeFire && writeOk) begin
            for (int i = 0; i < numSlots; i++) begin
                if (awAddr[5:2] == 4'(i)) begin
                    slots[i] <= mergeBytes(slots[i], wData, wStrb);
                end
            end
        end
    end

    for (genvar g = 0; g < numSlots; g++) begin : genFlatten
        assign entityTable[g*EW +: EW] = slots[g];
    end

endmodule

//--- rtl/tileLocator.sv
`timescale 1ns/1ps

module tileLocator #(
    parameter int unsigned upscale = 5,
    parameter int unsigned hTiles  = 16,
    parameter int unsigned vTiles  = 12
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [spritePkg::COORD_W-1:0] pixelH,
    input  logic [spritePkg::COORD_W-1:0] pixelV,
    input  logic                          pixelValid,
    output logic                          locValid,
    output logic [3:0]                    tileCol,
    output logic [3:0]                    tileRow,
    output logic [2:0]                    spriteRow,
    output logic [2:0]                    spriteCol,
    output logic                          onScreen
);
    localparam int CW = spritePkg::COORD_W;

    // screen pixels covered by one tile side
    localparam int TILE_PIX = upscale * spritePkg::TILE_SIZE;
    localparam logic [CW-1:0] TILE_DIV  = CW'(TILE_PIX);
    localparam logic [CW-1:0] SCALE_DIV = CW'(upscale);
    localparam logic [CW-1:0] H_LIMIT   = CW'(hTiles * TILE_PIX);
    localparam logic [CW-1:0] V_LIMIT   = CW'(vTiles * TILE_PIX);

    logic [CW-1:0] hTile;
    logic [CW-1:0] vTile;
    logic [CW-1:0] hSub;
    logic [CW-1:0] vSub;

    // constant divisors, so these fold into fixed arithmetic
    assign hTile = pixelH / TILE_DIV;
    assign vTile = pixelV / TILE_DIV;
    assign hSub  = pixelH / SCALE_DIV;
    assign vSub  = pixelV / SCALE_DIV;

    always_ff @(posedge clk) begin
        if (!reset) begin
            locValid <= 1'b0;
        end else begin
            locValid <= pixelValid;
        end
    end

    always_ff @(posedge clk) begin
        tileCol   <= hTile[3:0];
        tileRow   <= vTile[3:0];
        // sprite pixel index within the tile
        spriteCol <= 3'(hSub % CW'(spritePkg::TILE_SIZE));
        spriteRow <= 3'(vSub % CW'(spritePkg::TILE_SIZE));
        onScreen  <= (pixelH < H_LIMIT) && (pixelV < V_LIMIT);
    end

endmodule

//--- rtl/entityMatcher.sv
`timescale 1ns/1ps

module entityMatcher #(
    parameter int unsigned numSlots = 9
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [numSlots*spritePkg::ENTITY_W-1:0] entityTable,
    input  logic                                   locValid,
    input  logic [3:0]                             tileCol,
    input  logic [3:0]                             tileRow,
    input  logic [2:0]                             spriteRow,
    input  logic [2:0]                             spriteCol,
    input  logic                                   onScreen,
    output logic                                   fetchValid,
    output logic                                   hit,
    output logic [3:0]                             spriteId,
    output logic [1:0]                             orientation,
    output logic [2:0]                             lineIndex,
    output logic [2:0]                             columnIndex
);
    localparam int EW = spritePkg::ENTITY_W;

    logic [numSlots-1:0] slotHit;
    logic                anyHit;
    logic [EW-1:0]       winEntity;
    spritePkg::drawMode  winMode;
    logic [2:0]          winLine;

    // all slots compared at once
    for (genvar g = 0; g < numSlots; g++) begin : genSlot
        logic [EW-1:0]      entity;
        spritePkg::drawMode mode;
        logic [3:0]         id;
        logic [3:0]         col;
        logic [3:0]         row;
        logic [4:0]         lastCol;
        logic               active;

        assign entity = entityTable[g*EW +: EW];
        assign mode   = spritePkg::drawMode'(entity[spritePkg::MODE_LSB +: 2]);
        assign id     = entity[spritePkg::ID_LSB +: 4];
        assign col    = entity[spritePkg::COL_LSB +: 4];
        assign row    = entity[spritePkg::ROW_LSB +: 4];
        assign active = (id != spritePkg::ID_NONE) && (mode != spritePkg::MODE_OFF);

        // five bits so an array near the right edge cannot wrap
        assign lastCol = {1'b0, col} + ((mode == spritePkg::MODE_ARRAY) ?
                         {1'b0, entity[spritePkg::LEN_LSB +: 4]} : 5'd0);

        assign slotHit[g] = active && (tileRow == row) && (tileCol >= col)
                            && ({1'b0, tileCol} <= lastCol);
    end

    // walk down so the lowest slot number is left standing
    always_comb begin
        anyHit    = 1'b0;
        winEntity = spritePkg::ENTITY_RESET;
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (slotHit[i]) begin
                anyHit    = 1'b1;
                winEntity = entityTable[i*EW +: EW];
            end
        end
    end

    assign winMode = spritePkg::drawMode'(winEntity[spritePkg::MODE_LSB +: 2]);

    // vertical mirror for flip mode
    assign winLine = (winMode == spritePkg::MODE_FLIP) ? (3'd7 - spriteRow) : spriteRow;

    always_ff @(posedge clk) begin
        if (!reset) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= locValid;
        end
    end

    always_ff @(posedge clk) begin
        // truncated tile numbers off screen must never match
        hit         <= anyHit && onScreen;
        spriteId    <= winEntity[spritePkg::ID_LSB +: 4];
        orientation <= winEntity[spritePkg::ORIENT_LSB +: 2];
        lineIndex   <= winLine;
        columnIndex <= spriteCol;
    end

endmodule

//--- rtl/spriteRom.sv
`timescale 1ns/1ps

module spriteRom (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetchValid,
    input  logic       hit,
    input  logic [3:0] spriteId,
    input  logic [1:0] orientation,
    input  logic [2:0] lineIndex,
    input  logic [2:0] columnIndex,
    output logic       colour,
    output logic       colourValid
);
    logic [7:0] rowData;
    logic [7:0] rowReg;
    logic [2:0] colReg;
    logic       hitReg;

    // base pattern, (s*16 + r*29) ^ 0x5A in 8 bits
    function automatic logic [7:0] baseRow(input logic [3:0] s, input logic [2:0] r);
        logic [7:0] sum;
        sum = {s, 4'b0000} + (8'(r) * 8'd29);
        return sum ^ 8'h5A;
    endfunction

    function automatic logic [7:0] lookup(
        input logic [3:0] s,
        input logic [1:0] orient,
        input logic [2:0] r
    );
        logic [2:0] line;
        logic [7:0] raw;
        logic [7:0] result;
        // bit 1 flips vertically, bit 0 mirrors the row
        line = orient[1] ? (3'd7 - r) : r;
        raw  = baseRow(s, line);
        for (int b = 0; b < 8; b++) begin
            result[b] = orient[0] ? raw[7-b] : raw[b];
        end
        return result;
    endfunction

    assign rowData = lookup(spriteId, orientation, lineIndex);

    always_ff @(posedge clk) begin
        if (!reset) begin
            colourValid <= 1'b0;
            hitReg      <= 1'b0;
        end else begin
            colourValid <= fetchValid;
            hitReg      <= hit;
        end
    end

    always_ff @(posedge clk) begin
        rowReg <= rowData;
        colReg <= columnIndex;
    end

    // no hit means background, which is black
    assign colour = hitReg && rowReg[colReg];

endmodule

//--- rtl/frameBufferTop.sv
`timescale 1ns/1ps

module frameBufferTop #(
    parameter int unsigned numSlots = 9,
    parameter int unsigned upscale  = 5,
    parameter int unsigned hTiles   = 16,
    parameter int unsigned vTiles   = 12
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [5:0]                    awAddr,
    input  logic                          awValid,
    output logic                          awReady,
    input  logic [31:0]                   wData,
    input  logic [3:0]                    wStrb,
    input  logic                          wValid,
    output logic                          wReady,
    output logic [1:0]                    bResp,
    output logic                          bValid,
    input  logic                          bReady,
    input  logic [5:0]                    arAddr,
    input  logic                          arValid,
    output logic                          arReady,
    output logic [31:0]                   rData,
    output logic [1:0]                    rResp,
    output logic                          rValid,
    input  logic                          rReady,
    input  logic [spritePkg::COORD_W-1:0] pixelH,
    input  logic [spritePkg::COORD_W-1:0] pixelV,
    input  logic                          pixelValid,
    output logic                          colour,
    output logic                          colourValid
);
    logic [numSlots*spritePkg::ENTITY_W-1:0] entityTable;

    // stage 1 to stage 2
    logic       locValid;
    logic [3:0] tileCol;
    logic [3:0] tileRow;
    logic [2:0] spriteRow;
    logic [2:0] spriteCol;
    logic       onScreen;

    // stage 2 to stage 3
    logic       fetchValid;
    logic       hit;
    logic [3:0] spriteId;
    logic [1:0] orientation;
    logic [2:0] lineIndex;
    logic [2:0] columnIndex;

    entityRegs #(.numSlots(numSlots)) i_entityRegs (
        .clk(clk), .reset(reset),
        .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
        .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
        .bResp(bResp), .bValid(bValid), .bReady(bReady),
        .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
        .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
        .entityTable(entityTable)
    );

    tileLocator #(.upscale(upscale), .hTiles(hTiles), .vTiles(vTiles)) i_tileLocator (
        .clk(clk), .reset(reset),
        .pixelH(pixelH), .pixelV(pixelV), .pixelValid(pixelValid),
        .locValid(locValid), .tileCol(tileCol), .tileRow(tileRow),
        .spriteRow(spriteRow), .spriteCol(spriteCol), .onScreen(onScreen)
    );

    entityMatcher #(.numSlots(numSlots)) i_entityMatcher (
        .clk(clk), .reset(reset), .entityTable(entityTable),
        .locValid(locValid), .tileCol(tileCol), .tileRow(tileRow),
        .spriteRow(spriteRow), .spriteCol(spriteCol), .onScreen(onScreen),
        .fetchValid(fetchValid), .hit(hit), .spriteId(spriteId),
        .orientation(orientation), .lineIndex(lineIndex), .columnIndex(columnIndex)
    );

    spriteRom i_spriteRom (
        .clk(clk), .reset(reset),
        .fetchValid(fetchValid), .hit(hit), .spriteId(spriteId),
        .orientation(orientation), .lineIndex(lineIndex), .columnIndex(columnIndex),
        .colour(colour), .colourValid(colourValid)
    );

endmodule

//--- sim/tbFrameBuffer.sv
`timescale 1ns/1ps

module tbFrameBuffer;

    localparam int NUM_SLOTS = 9;
    localparam int LATENCY   = 3;
    localparam int WAIT_MAX  = 64;

    logic        clk;
    logic        reset;
    logic [5:0]  awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [5:0]  arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;
    logic [9:0]  pixelH;
    logic [9:0]  pixelV;
    logic        pixelValid;
    logic        colour;
    logic        colourValid;

    integer      seed = 32'ha3670f58;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    logic [19:0] shadow [NUM_SLOTS];
    logic        expQ [$];
    int          issueQ [$];

    frameBufferTop #(.numSlots(NUM_SLOTS), .upscale(5), .hTiles(16), .vTiles(12)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic timeoutAbort(input string what);
        errorCount++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("errors: %0d, checks: %0d", errorCount, checkCount);
        $display("TEST FAILED");
        $finish;
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [19:0] entityWord(input int id, input int orient, input int col,
                                               input int row, input int mode, input int len);
        return {4'(id), 2'(orient), 4'(col), 4'(row), 2'(mode), 4'(len)};
    endfunction

    // expected pixel from the shadow table
    function automatic logic expectedColour(input int h, input int v);
        int          tc;
        int          tr;
        int          sc;
        int          sr;
        int          line;
        int          extent;
        logic [19:0] e;
        logic [7:0]  pattern;
        if (h >= 640 || v >= 480) begin
            return 1'b0;
        end
        tc = h / 40;
        tr = v / 40;
        sc = (h / 5) % 8;
        sr = (v / 5) % 8;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            e = shadow[i];
            extent = (e[5:4] == 2'd1) ? int'(e[3:0]) : 0;
            if (e[19:16] != 4'd15 && e[5:4] != 2'd3 && int'(e[9:6]) == tr
                && tc >= int'(e[13:10]) && tc <= int'(e[13:10]) + extent) begin
                line = (e[5:4] == 2'd2) ? 7 - sr : sr;
                // orientation bit 1 is a second vertical flip
                if (e[15]) begin
                    line = 7 - line;
                end
                pattern = 8'((int'(e[19:16]) * 16 + line * 29) ^ 'h5A);
                return e[14] ? pattern[7 - sc] : pattern[sc];
            end
        end
        return 1'b0;
    endfunction

    task automatic busWrite(input logic [5:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
        int   waited;
        logic stall;
        awAddr  = addr;
        wData   = data;
        wStrb   = strb;
        awValid = 1'b1;
        wValid  = 1'b1;
        waited  = 0;
        while (!(awReady && wReady)) begin
            if (waited++ > WAIT_MAX) timeoutAbort("write address handshake");
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        awValid = 1'b0;
        wValid  = 1'b0;
        waited  = 0;
        stall   = 1'b1;
        // random back-pressure on the response
        while (stall) begin
            if (waited++ > WAIT_MAX) timeoutAbort("write response");
            bReady = ($random(seed) & 3) != 0;
            stall  = !(bValid && bReady);
            if (!stall) begin
                resp = bResp;
            end
            @(posedge clk);
            #5;
        end
        bReady = 1'b0;
    endtask

    task automatic busRead(input logic [5:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int   waited;
        logic stall;
        arAddr  = addr;
        arValid = 1'b1;
        waited  = 0;
        while (!arReady) begin
            if (waited++ > WAIT_MAX) timeoutAbort("read address handshake");
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        arValid = 1'b0;
        waited  = 0;
        stall   = 1'b1;
        while (stall) begin
            if (waited++ > WAIT_MAX) timeoutAbort("read data");
            rReady = ($random(seed) & 3) != 0;
            stall  = !(rValid && rReady);
            if (!stall) begin
                data = rData;
                resp = rResp;
            end
            @(posedge clk);
            #5;
        end
        rReady = 1'b0;
    endtask

    task automatic writeEntity(input int addr, input logic [31:0] data, input logic [3:0] strb);
        logic [1:0]  resp;
        logic [19:0] mask;
        logic        good;
        good = (addr % 4 == 0) && (addr / 4 < NUM_SLOTS);
        busWrite(6'(addr), data, strb, resp);
        checkEq(32'(resp), good ? 32'd0 : 32'd2, $sformatf("write response at %0d", addr));
        if (good) begin
            mask = {{4{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            shadow[addr / 4] = (shadow[addr / 4] & ~mask) | (data[19:0] & mask);
        end
    endtask

    task automatic readEntity(input int addr);
        logic [31:0] data;
        logic [1:0]  resp;
        logic        good;
        good = (addr % 4 == 0) && (addr / 4 < NUM_SLOTS);
        busRead(6'(addr), data, resp);
        checkEq(32'(resp), good ? 32'd0 : 32'd2, $sformatf("read response at %0d", addr));
        checkEq(data, good ? {12'd0, shadow[addr / 4]} : 32'd0,
                $sformatf("read data at %0d", addr));
    endtask

    task automatic clearSlots();
        for (int i = 0; i < NUM_SLOTS; i++) begin
            writeEntity(4 * i, entityWord(15, 0, 0, 0, 3, 0), 4'hF);
        end
    endtask

    task automatic sendPixel(input int h, input int v);
        pixelH     = 10'(h);
        pixelV     = 10'(v);
        pixelValid = 1'b1;
        expQ.push_back(expectedColour(h, v));
        issueQ.push_back(cycleCount);
        @(posedge clk);
        #5;
        pixelValid = 1'b0;
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            if (waited++ > WAIT_MAX) timeoutAbort("pixel pipeline to drain");
            @(posedge clk);
            #5;
        end
    endtask

    // every pixel of a row of tiles from left to right
    task automatic scanTiles(input int col, input int row, input int count);
        for (int y = row * 40; y < row * 40 + 40; y++) begin
            for (int x = col * 40; x < (col + count) * 40; x++) begin
                sendPixel(x, y);
            end
        end
        drainPipe();
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (colourValid) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("colour output at %0t ns with no pixel in flight", $time);
            end else begin
                checkEq(32'(colour), 32'(expQ.pop_front()), "pixel colour");
                checkEq(cycleCount - issueQ.pop_front(), LATENCY, "pixel latency");
            end
        end
    end

    initial begin
        reset      = 1'b0;
        awAddr     = '0;
        awValid    = 1'b0;
        wData      = '0;
        wStrb      = '0;
        wValid     = 1'b0;
        bReady     = 1'b0;
        arAddr     = '0;
        arValid    = 1'b0;
        rReady     = 1'b0;
        pixelH     = '0;
        pixelV     = '0;
        pixelValid = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            shadow[i] = entityWord(15, 0, 0, 0, 3, 0);
        end
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b1;

        checkEq(32'(colourValid), 0, "colourValid after reset");
        checkEq(32'(awReady), 0, "awReady after reset");
        checkEq(32'(wReady), 0, "wReady after reset");
        checkEq(32'(bValid), 0, "bValid after reset");
        checkEq(32'(arReady), 1, "arReady after reset");
        checkEq(32'(rValid), 0, "rValid after reset");
        for (int i = 0; i < NUM_SLOTS; i++) begin
            readEntity(4 * i);
        end

        // full and partial strobes with the upper bits dropped
        writeEntity(0, 32'hFFFA_5C3E, 4'hF);
        writeEntity(4, 32'h0001_2345, 4'h1);
        writeEntity(8, 32'h000A_BCDE, 4'h6);
        writeEntity(12, 32'h1234_5678, 4'h4);
        for (int i = 0; i < 8; i++) begin
            writeEntity(4 * randBelow(NUM_SLOTS), $random(seed), 4'(randBelow(16)));
        end
        writeEntity(36, 32'h0003_0000, 4'hF);
        writeEntity(60, 32'h0003_0000, 4'hF);
        writeEntity(2, 32'h0003_0000, 4'hF);
        writeEntity(7, 32'h0003_0000, 4'hF);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            readEntity(4 * i);
        end
        readEntity(36);
        readEntity(44);
        readEntity(63);
        readEntity(1);
        readEntity(6);
        clearSlots();

        // one sprite per orientation with a length that normal mode ignores
        for (int o = 0; o < 4; o++) begin
            writeEntity(0, entityWord(3 + o, o, 5, 4, 0, 6), 4'hF);
            scanTiles(5, 4, 2);
        end
        clearSlots();

        // array clipped at the right edge and then a flipped sprite
        writeEntity(4, entityWord(7, 0, 13, 2, 1, 5), 4'hF);
        scanTiles(12, 2, 4);
        writeEntity(8, entityWord(9, 1, 2, 7, 2, 0), 4'hF);
        scanTiles(2, 7, 1);

        // slot 3 overlaps slot 6 on tile 8
        writeEntity(24, entityWord(1, 2, 8, 9, 0, 0), 4'hF);
        writeEntity(12, entityWord(10, 0, 7, 9, 1, 2), 4'hF);
        scanTiles(7, 9, 3);

        // off screen coordinates that alias tile 0 or row 12
        writeEntity(16, entityWord(5, 0, 0, 12, 0, 0), 4'hF);
        writeEntity(20, entityWord(6, 0, 0, 0, 0, 0), 4'hF);
        for (int x = 640; x < 700; x++) begin
            sendPixel(x, 3);
        end
        for (int y = 480; y < 520; y++) begin
            sendPixel(3, y);
        end
        sendPixel(1023, 1023);
        drainPipe();

        // random scene and pixel stream with gaps
        for (int i = 0; i < NUM_SLOTS; i++) begin
            writeEntity(4 * i, entityWord(randBelow(16), randBelow(4), randBelow(16),
                        randBelow(12), randBelow(4), randBelow(16)), 4'hF);
        end
        for (int n = 0; n < 4000; n++) begin
            if (randBelow(4) == 0) begin
                @(posedge clk);
                #5;
            end else begin
                sendPixel(randBelow(700), randBelow(520));
            end
        end
        drainPipe();

        $display("errors: %0d, checks: %0d", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/spritePkg.sv
rtl/entityRegs.sv
rtl/tileLocator.sv
rtl/entityMatcher.sv
rtl/spriteRom.sv
rtl/frameBufferTop.sv
sim/tbFrameBuffer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module tbFrameBuffer -f files.f -o simFrameBuffer \
    && ./obj_dir/simFrameBuffer > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -q "TEST FAILED" "$LOG" && exit 1 || exit 0
